// ==== all.f ====
+incdir+verilog
verilog/bru_pkg.sv
verilog/bru_operand_stage.sv
verilog/bru_exec_stage.sv
verilog/bru_output_stage.sv
verilog/bru_pipeline.sv
verilog/bru_pipeline_wrapper.sv
bench/bru_tb.sv

// ==== Bender.yml ====
package:
  name: bru

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/bru_pkg.sv
      - verilog/bru_operand_stage.sv
      - verilog/bru_exec_stage.sv
      - verilog/bru_output_stage.sv
      - verilog/bru_pipeline.sv
      - verilog/bru_pipeline_wrapper.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/bru_tb.sv

// ==== bench/bru_tb.sv ====
`timescale 1ns/1ps

`include "bru_settings.svh"

module bru_tb;
	import bru_pkg::*;

	// operand source codes used by the table
	localparam logic [1:0] src_reg = 2'd0;
	localparam logic [1:0] src_fwd = 2'd1;
	localparam logic [1:0] src_zero = 2'd2;

	localparam int row_count = 16;
	localparam int cycles_per_row = 40;
	localparam int cycle_limit = cycles_per_row * row_count;

	// one issued op with its expected operands and output conditions
	typedef struct packed {
		bru_op_t op;
		logic [31:0] pc;
		logic [31:0] pred_pc;
		logic [19:0] imm;
		logic [31:0] a;
		logic [31:0] b;
		logic [1:0] pred;
		logic [1:0] a_src;
		logic [1:0] b_src;
		logic [1:0] bank;
		logic rnd;
		logic [3:0] hold;
		logic rrdy;
	} row_t;

	logic CLK;
	logic nRST;
	logic next_issue_valid;
	bru_issue_t next_issue;
	logic last_issue_ready;
	logic next_A_reg_read_resp_valid;
	logic [31:0] next_A_reg_read_resp_data;
	logic next_B_reg_read_resp_valid;
	logic [31:0] next_B_reg_read_resp_data;
	logic [`BRU_PRF_BANK_COUNT-1:0][31:0] next_forward_data_by_bank;
	logic last_WB_valid;
	bru_wb_t last_WB;
	logic next_WB_ready;
	logic last_branch_notif_valid;
	bru_notif_t last_branch_notif;
	logic next_branch_notif_ready;

	row_t rows [row_count];
	logic [`BRU_PRF_BANK_COUNT-1:0][31:0] fwd_values;
	logic [15:0] stim_lfsr;
	logic [15:0] rdy_lfsr;
	bru_notif_t notif_q[$];
	int notif_row_q[$];
	bru_wb_t wb_q[$];
	int wb_row_q[$];
	int cycle_count;
	int stall_until;
	logic rand_ready;
	logic wb_ready_d2;
	logic notif_ready_d2;

	bru_pipeline_wrapper u_bru_pipeline_wrapper (
		.CLK(CLK),
		.nRST(nRST),
		.next_issue_valid(next_issue_valid),
		.next_issue(next_issue),
		.last_issue_ready(last_issue_ready),
		.next_A_reg_read_resp_valid(next_A_reg_read_resp_valid),
		.next_A_reg_read_resp_data(next_A_reg_read_resp_data),
		.next_B_reg_read_resp_valid(next_B_reg_read_resp_valid),
		.next_B_reg_read_resp_data(next_B_reg_read_resp_data),
		.next_forward_data_by_bank(next_forward_data_by_bank),
		.last_WB_valid(last_WB_valid),
		.last_WB(last_WB),
		.next_WB_ready(next_WB_ready),
		.last_branch_notif_valid(last_branch_notif_valid),
		.last_branch_notif(last_branch_notif),
		.next_branch_notif_ready(next_branch_notif_ready)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------

	// galois lfsr with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		if (state[0])
			return (state >> 1) ^ 16'hb400;
		else
			return state >> 1;
	endfunction

	task automatic take_stim_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			stim_lfsr = lfsr_step(stim_lfsr);
			bits = {bits[30:0], stim_lfsr[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		if (expected !== actual) begin
			$display("mismatch %s expected %0h actual %0h", name, expected, actual);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	task automatic stop_with_error(input string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] operand_value(input logic [1:0] src,
			input logic [1:0] bank, input logic [31:0] reg_value);
		if (src == src_zero)
			return 32'd0;
		else if (src == src_fwd)
			return fwd_values[bank];
		else
			return reg_value;
	endfunction

	// reference model for the branch notification
	function automatic bru_notif_t model_notif(input row_t r, input logic [31:0] a,
			input logic [31:0] b, input logic [`BRU_LOG_ROB_ENTRIES-1:0] rob);
		bru_notif_t n;
		logic taken;
		logic [31:0] br_target;
		logic [31:0] dest;
		int counter;
		br_target = r.pc + ({{20{r.imm[11]}}, r.imm[11:0]} << 1);
		case (r.op)
			BEQ: taken = a == b;
			BNE: taken = a != b;
			// with differing signs the negative one is smaller
			BLT: taken = (a[31] != b[31]) ? a[31] : a < b;
			BGE: taken = (a[31] != b[31]) ? b[31] : a >= b;
			BLTU: taken = a < b;
			BGEU: taken = !(a < b);
			default: taken = 1'b1;
		endcase
		case (r.op)
			JAL: dest = r.pc + ({{12{r.imm[19]}}, r.imm} << 1);
			JALR: dest = (a + {{20{r.imm[11]}}, r.imm[11:0]}) & 32'hffff_fffe;
			default: dest = taken ? br_target : r.pc + 32'd4;
		endcase
		counter = taken ? r.pred + 1 : r.pred - 1;
		if (counter > 3)
			counter = 3;
		if (counter < 0)
			counter = 0;
		n.ROB_index = rob;
		n.is_mispredict = dest != r.pred_pc;
		n.is_taken = taken;
		n.updated_pred_info = counter[1:0];
		n.start_PC = r.pc;
		n.target_PC = dest;
		return n;
	endfunction

	// ------------------------------------------------------------------------
	// issue one table row and answer its register reads
	// ------------------------------------------------------------------------

	task automatic issue_row(input int idx);
		row_t r;
		bru_issue_t iss;
		bru_wb_t wb;
		logic [31:0] a_raw;
		logic [31:0] b_raw;
		logic [31:0] a_val;
		logic [31:0] b_val;
		logic [31:0] delays;
		logic [1:0] b_bank;
		logic [`BRU_LOG_ROB_ENTRIES-1:0] rob;
		logic [`BRU_LOG_PR_COUNT-1:0] pr;
		r = rows[idx];
		rob = idx[`BRU_LOG_ROB_ENTRIES-1:0];
		pr = idx[`BRU_LOG_PR_COUNT-1:0] + 1'b1;
		b_bank = r.bank + 2'd1;
		if (r.rnd) begin
			take_stim_bits(32, a_raw);
			take_stim_bits(32, b_raw);
		end else begin
			a_raw = r.a;
			b_raw = r.b;
		end
		// response delays of 0 to 3 cycles for A and B
		take_stim_bits(4, delays);
		a_val = operand_value(r.a_src, r.bank, a_raw);
		b_val = operand_value(r.b_src, b_bank, b_raw);

		iss = '0;
		iss.op = r.op;
		iss.pred_info = r.pred;
		iss.PC = r.pc;
		iss.pred_PC = r.pred_pc;
		iss.imm = r.imm;
		iss.A_unneeded_or_is_zero = r.a_src == src_zero;
		iss.A_forward = r.a_src == src_fwd;
		iss.A_bank = r.bank;
		iss.B_unneeded_or_is_zero = r.b_src == src_zero;
		iss.B_forward = r.b_src == src_fwd;
		iss.B_bank = b_bank;
		iss.dest_PR = pr;
		iss.ROB_index = rob;

		do
			@(negedge CLK);
		while (!last_issue_ready);
		if (cycle_count + r.hold > stall_until)
			stall_until <= cycle_count + r.hold;
		rand_ready <= r.rrdy;
		notif_q.push_back(model_notif(r, a_val, b_val, rob));
		notif_row_q.push_back(idx);
		if (r.op == JAL || r.op == JALR) begin
			wb.data = r.pc + 32'd4;
			wb.PR = pr;
			wb.ROB_index = rob;
			wb_q.push_back(wb);
			wb_row_q.push_back(idx);
		end
		next_issue = iss;
		next_issue_valid = 1'b1;

		for (int k = 1; k <= 5; k++) begin
			@(negedge CLK);
			next_issue_valid = 1'b0;
			next_A_reg_read_resp_valid = (r.a_src == src_reg) && (delays[1:0] + 1 == k);
			next_A_reg_read_resp_data = next_A_reg_read_resp_valid ? a_val : 32'd0;
			next_B_reg_read_resp_valid = (r.b_src == src_reg) && (delays[3:2] + 1 == k);
			next_B_reg_read_resp_data = next_B_reg_read_resp_valid ? b_val : 32'd0;
		end
	endtask

	// ------------------------------------------------------------------------
	// output monitors, ready driver and cycle limit
	// ------------------------------------------------------------------------

	always @(negedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("timeout after %0d cycles, outputs still pending", cycle_count);
			$display("Checks failed");
			$fatal(1);
		end else begin
			// a transfer used the ready driven two falling edges ago
			if (last_WB_valid && wb_ready_d2) begin
				if (wb_q.size() == 0)
					stop_with_error("writeback appeared with none expected");
				else
					check_value($sformatf("writeback row %0d", wb_row_q.pop_front()),
						wb_q.pop_front(), last_WB);
			end
			if (last_branch_notif_valid && notif_ready_d2) begin
				if (notif_q.size() == 0)
					stop_with_error("branch notification appeared with none expected");
				else
					check_value($sformatf("notification row %0d", notif_row_q.pop_front()),
						notif_q.pop_front(), last_branch_notif);
			end
			wb_ready_d2 = next_WB_ready;
			notif_ready_d2 = next_branch_notif_ready;

			if (cycle_count < stall_until) begin
				next_WB_ready = 1'b0;
				next_branch_notif_ready = 1'b0;
			end else if (rand_ready) begin
				rdy_lfsr = lfsr_step(rdy_lfsr);
				next_WB_ready = rdy_lfsr[0];
				rdy_lfsr = lfsr_step(rdy_lfsr);
				next_branch_notif_ready = rdy_lfsr[0];
			end else begin
				next_WB_ready = 1'b1;
				next_branch_notif_ready = 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// stimulus table and main sequence
	// ------------------------------------------------------------------------

	initial begin
		logic [31:0] word;
		nRST = 1'b0;
		next_issue_valid = 1'b0;
		next_issue = '0;
		next_A_reg_read_resp_valid = 1'b0;
		next_A_reg_read_resp_data = '0;
		next_B_reg_read_resp_valid = 1'b0;
		next_B_reg_read_resp_data = '0;
		next_forward_data_by_bank = '0;
		next_WB_ready = 1'b0;
		next_branch_notif_ready = 1'b0;
		stim_lfsr = 16'd66;
		rdy_lfsr = 16'd66;
		cycle_count = 0;
		stall_until = 0;
		rand_ready = 1'b0;
		wb_ready_d2 = 1'b0;
		notif_ready_d2 = 1'b0;

		// op, pc, pred_pc, imm, a, b, pred, a_src, b_src, bank, rnd, hold, rrdy
		rows[0] = '{BEQ, 32'h1000, 32'h1010, 20'h00008, 32'd5, 32'd5,
			2'd1, src_reg, src_reg, 2'd0, 1'b0, 4'd0, 1'b0};
		rows[1] = '{BEQ, 32'h1100, 32'h1110, 20'h00008, 32'd5, 32'd6,
			2'd0, src_reg, src_reg, 2'd0, 1'b0, 4'd0, 1'b0};
		rows[2] = '{BNE, 32'h2000, 32'h2004, 20'h00ffc, 32'd1, 32'd2,
			2'd3, src_reg, src_reg, 2'd0, 1'b0, 4'd0, 1'b0};
		rows[3] = '{BNE, 32'h2100, 32'h2104, 20'h00ffc, 32'h8000_0000, 32'h8000_0000,
			2'd3, src_reg, src_reg, 2'd0, 1'b0, 4'd0, 1'b0};
		rows[4] = '{BLT, 32'h3000, 32'h3004, 20'h00010, 32'hffff_ffff, 32'd1,
			2'd2, src_reg, src_reg, 2'd0, 1'b0, 4'd0, 1'b0};
		rows[5] = '{BLT, 32'h3100, 32'h3104, 20'h00010, 32'h7fff_ffff, 32'h8000_0000,
			2'd1, src_reg, src_reg, 2'd0, 1'b0, 4'd0, 1'b0};
		rows[6] = '{BGE, 32'h3200, 32'h41fe, 20'h007ff, 32'h8000_0000, 32'h8000_0000,
			2'd2, src_reg, src_reg, 2'd0, 1'b0, 4'd0, 1'b0};
		rows[7] = '{BGE, 32'h3300, 32'h2300, 20'h00800, 32'h8000_0000, 32'h7fff_ffff,
			2'd2, src_reg, src_reg, 2'd0, 1'b0, 4'd0, 1'b0};
		rows[8] = '{BLTU, 32'h5000, 32'h5004, 20'h00040, 32'd1, 32'hffff_ffff,
			2'd0, src_reg, src_reg, 2'd0, 1'b0, 4'd0, 1'b0};
		rows[9] = '{BLTU, 32'h5100, 32'h5104, 20'h00040, 32'hffff_ffff, 32'd1,
			2'd1, src_reg, src_zero, 2'd0, 1'b0, 4'd0, 1'b0};
		// zero B is the unsigned minimum so any random A takes the branch
		rows[10] = '{BGEU, 32'h6000, 32'h6004, 20'h00020, 32'd0, 32'd0,
			2'd1, src_reg, src_zero, 2'd0, 1'b1, 4'd0, 1'b1};
		// an lfsr word of 32 bits is never zero so zero A falls through
		rows[11] = '{BGEU, 32'h6100, 32'h6140, 20'h00020, 32'd0, 32'd0,
			2'd2, src_zero, src_fwd, 2'd1, 1'b0, 4'd0, 1'b1};
		// jal view gives 0x6000 where the branch view would give 0x4000
		rows[12] = '{JAL, 32'h4000, 32'h6000, 20'h01000, 32'd0, 32'd0,
			2'd1, src_zero, src_zero, 2'd0, 1'b0, 4'd10, 1'b0};
		// pad bits set since jalr reads only the low 12 bits
		rows[13] = '{JALR, 32'h4100, 32'h5000, 20'hab001, 32'h0000_5000, 32'd0,
			2'd3, src_reg, src_zero, 2'd0, 1'b0, 4'd0, 1'b1};
		rows[14] = '{BLT, 32'h7000, 32'h7004, 20'h00100, 32'd0, 32'd0,
			2'd1, src_reg, src_reg, 2'd0, 1'b1, 4'd15, 1'b0};
		rows[15] = '{JALR, 32'h7100, 32'h0000_0000, 20'h00ff0, 32'd0, 32'd0,
			2'd0, src_fwd, src_zero, 2'd3, 1'b0, 4'd0, 1'b1};

		// forward banks hold one random word each for the whole run
		for (int k = 0; k < `BRU_PRF_BANK_COUNT; k++) begin
			take_stim_bits(32, word);
			fwd_values[k] = word;
		end
		next_forward_data_by_bank = fwd_values;

		repeat (2) @(posedge CLK);
		@(negedge CLK);
		check_value("reset issue ready", 128'd0, last_issue_ready);
		nRST = 1'b1;

		// quiet outputs before the first issue
		repeat (6) begin
			@(negedge CLK);
			check_value("idle writeback valid", 128'd0, last_WB_valid);
			check_value("idle notification valid", 128'd0, last_branch_notif_valid);
		end

		for (int i = 0; i < row_count; i++)
			issue_row(i);

		while (notif_q.size() != 0 || wb_q.size() != 0)
			@(negedge CLK);
		// stray outputs would still show up here
		repeat (10) @(negedge CLK);

		$display("All checks passed");
		$finish;
	end

endmodule

// ==== verilog/bru_pipeline_wrapper.sv ====
`timescale 1ns/1ps

`include "bru_settings.svh"

module bru_pipeline_wrapper (
	input logic CLK,
	input logic nRST,

	// issue from the branch queue
	input logic next_issue_valid,
	input bru_pkg::bru_issue_t next_issue,
	output logic last_issue_ready,

	// register-read responses
	input logic next_A_reg_read_resp_valid,
	input logic [31:0] next_A_reg_read_resp_data,
	input logic next_B_reg_read_resp_valid,
	input logic [31:0] next_B_reg_read_resp_data,

	input logic [`BRU_PRF_BANK_COUNT-1:0][31:0] next_forward_data_by_bank,

	// writeback to the register file
	output logic last_WB_valid,
	output bru_pkg::bru_wb_t last_WB,
	input logic next_WB_ready,

	// notification to the ROB
	output logic last_branch_notif_valid,
	output bru_pkg::bru_notif_t last_branch_notif,
	input logic next_branch_notif_ready
);
	import bru_pkg::*;

	// ------------------------------------------------------------------------
	// pipeline side of the boundary registers
	// ------------------------------------------------------------------------

	logic issue_valid;
	bru_issue_t issue;
	logic issue_ready;
	logic A_reg_read_resp_valid;
	logic [31:0] A_reg_read_resp_data;
	logic B_reg_read_resp_valid;
	logic [31:0] B_reg_read_resp_data;
	logic [`BRU_PRF_BANK_COUNT-1:0][31:0] forward_data_by_bank;
	logic WB_valid;
	bru_wb_t WB;
	logic WB_ready;
	logic branch_notif_valid;
	bru_notif_t branch_notif;
	logic branch_notif_ready;

	bru_pipeline u_bru_pipeline (.*);

	// ------------------------------------------------------------------------
	// one cycle on every input and every output
	// ------------------------------------------------------------------------

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			issue_valid <= 1'b0;
			issue <= '0;
			last_issue_ready <= 1'b0;
			A_reg_read_resp_valid <= 1'b0;
			A_reg_read_resp_data <= '0;
			B_reg_read_resp_valid <= 1'b0;
			B_reg_read_resp_data <= '0;
			forward_data_by_bank <= '0;
			last_WB_valid <= 1'b0;
			last_WB <= '0;
			WB_ready <= 1'b0;
			last_branch_notif_valid <= 1'b0;
			last_branch_notif <= '0;
			branch_notif_ready <= 1'b0;
		end else begin
			issue_valid <= next_issue_valid;
			issue <= next_issue;
			last_issue_ready <= issue_ready;
			A_reg_read_resp_valid <= next_A_reg_read_resp_valid;
			A_reg_read_resp_data <= next_A_reg_read_resp_data;
			B_reg_read_resp_valid <= next_B_reg_read_resp_valid;
			B_reg_read_resp_data <= next_B_reg_read_resp_data;
			forward_data_by_bank <= next_forward_data_by_bank;
			last_WB_valid <= WB_valid;
			last_WB <= WB;
			WB_ready <= next_WB_ready;
			last_branch_notif_valid <= branch_notif_valid;
			last_branch_notif <= branch_notif;
			branch_notif_ready <= next_branch_notif_ready;
		end
	end

endmodule

// ==== verilog/bru_pipeline.sv ====
`timescale 1ns/1ps

`include "bru_settings.svh"

module bru_pipeline (
	input logic CLK,
	input logic nRST,

	input logic issue_valid,
	input bru_pkg::bru_issue_t issue,
	output logic issue_ready,

	input logic A_reg_read_resp_valid,
	input logic [31:0] A_reg_read_resp_data,
	input logic B_reg_read_resp_valid,
	input logic [31:0] B_reg_read_resp_data,

	input logic [`BRU_PRF_BANK_COUNT-1:0][31:0] forward_data_by_bank,

	output logic WB_valid,
	output bru_pkg::bru_wb_t WB,
	input logic WB_ready,

	output logic branch_notif_valid,
	output bru_pkg::bru_notif_t branch_notif,
	input logic branch_notif_ready
);
	import bru_pkg::*;

	// operand stage to exec
	logic opnd_valid;
	logic opnd_ready;
	bru_exec_in_t opnd;

	// exec to output stage
	logic ex_valid;
	logic ex_ready;
	logic ex_wb_needed;
	bru_wb_t ex_wb;
	bru_notif_t ex_notif;

	bru_operand_stage u_operand_stage (
		.CLK(CLK),
		.nRST(nRST),
		.issue_valid(issue_valid),
		.issue(issue),
		.issue_ready(issue_ready),
		.A_reg_read_resp_valid(A_reg_read_resp_valid),
		.A_reg_read_resp_data(A_reg_read_resp_data),
		.B_reg_read_resp_valid(B_reg_read_resp_valid),
		.B_reg_read_resp_data(B_reg_read_resp_data),
		.forward_data_by_bank(forward_data_by_bank),
		.out_valid(opnd_valid),
		.out(opnd),
		.out_ready(opnd_ready)
	);

	bru_exec_stage u_exec_stage (
		.CLK(CLK),
		.nRST(nRST),
		.in_valid(opnd_valid),
		.in(opnd),
		.in_ready(opnd_ready),
		.out_valid(ex_valid),
		.wb_needed(ex_wb_needed),
		.wb(ex_wb),
		.notif(ex_notif),
		.out_ready(ex_ready)
	);

	// output stage ready ripples back through exec to issue_ready
	bru_output_stage u_output_stage (
		.CLK(CLK),
		.nRST(nRST),
		.in_valid(ex_valid),
		.wb_needed(ex_wb_needed),
		.wb(ex_wb),
		.notif(ex_notif),
		.in_ready(ex_ready),
		.WB_valid(WB_valid),
		.WB(WB),
		.WB_ready(WB_ready),
		.branch_notif_valid(branch_notif_valid),
		.branch_notif(branch_notif),
		.branch_notif_ready(branch_notif_ready)
	);

endmodule

// ==== verilog/bru_output_stage.sv ====
`timescale 1ns/1ps

module bru_output_stage (
	input logic CLK,
	input logic nRST,

	input logic in_valid,
	input logic wb_needed,
	input bru_pkg::bru_wb_t wb,
	input bru_pkg::bru_notif_t notif,
	output logic in_ready,

	output logic WB_valid,
	output bru_pkg::bru_wb_t WB,
	input logic WB_ready,

	output logic branch_notif_valid,
	output bru_pkg::bru_notif_t branch_notif,
	input logic branch_notif_ready
);
	logic wb_free;
	logic notif_free;
	logic accept;

	// a slot is free when empty or draining this cycle
	assign wb_free = !WB_valid || WB_ready;
	assign notif_free = !branch_notif_valid || branch_notif_ready;

	// every op sends a notification, only jumps write back
	assign in_ready = notif_free && (!wb_needed || wb_free);
	assign accept = in_valid && in_ready;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			WB_valid <= 1'b0;
			branch_notif_valid <= 1'b0;
		end else begin
			if (accept && wb_needed)
				WB_valid <= 1'b1;
			else if (WB_ready)
				WB_valid <= 1'b0;

			if (accept)
				branch_notif_valid <= 1'b1;
			else if (branch_notif_ready)
				branch_notif_valid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (accept && wb_needed)
			WB <= wb;
		if (accept)
			branch_notif <= notif;
	end

	// stalled slots hold steady until taken
	assert property (@(posedge CLK) disable iff (!nRST)
		WB_valid && !WB_ready |=> WB_valid && $stable(WB));
	assert property (@(posedge CLK) disable iff (!nRST)
		branch_notif_valid && !branch_notif_ready |=>
			branch_notif_valid && $stable(branch_notif));

endmodule

// ==== verilog/bru_exec_stage.sv ====
`timescale 1ns/1ps

module bru_exec_stage (
	input logic CLK,
	input logic nRST,

	input logic in_valid,
	input bru_pkg::bru_exec_in_t in,
	output logic in_ready,

	output logic out_valid,
	output logic wb_needed,
	output bru_pkg::bru_wb_t wb,
	output bru_pkg::bru_notif_t notif,
	input logic out_ready
);
	import bru_pkg::*;

	logic [31:0] br_offset;
	logic [31:0] jal_offset;
	logic [31:0] jalr_sum;
	logic [31:0] target;
	logic [31:0] link_pc;
	logic [31:0] next_pc;
	logic taken;
	logic is_jump;
	logic [1:0] counter_next;
	logic accept;

	// halfword offsets, doubled into bytes
	assign br_offset = {{19{in.imm.br.offset[11]}}, in.imm.br.offset, 1'b0};
	assign jal_offset = {{11{in.imm.jal[19]}}, in.imm.jal, 1'b0};
	assign jalr_sum = in.A + {{20{in.imm.br.offset[11]}}, in.imm.br.offset};
	assign link_pc = in.PC + 32'd4;
	assign is_jump = (in.op == JAL) || (in.op == JALR);

	always_comb begin
		case (in.op)
			BEQ: taken = in.A == in.B;
			BNE: taken = in.A != in.B;
			BLT: taken = $signed(in.A) < $signed(in.B);
			BGE: taken = $signed(in.A) >= $signed(in.B);
			BLTU: taken = in.A < in.B;
			BGEU: taken = in.A >= in.B;
			JAL, JALR: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		case (in.op)
			JAL: target = in.PC + jal_offset;
			JALR: target = {jalr_sum[31:1], 1'b0};
			default: target = in.PC + br_offset;
		endcase
	end

	assign next_pc = taken ? target : link_pc;

	// saturating 2-bit counter
	always_comb begin
		if (taken)
			counter_next = (in.pred_info == 2'b11) ? 2'b11 : in.pred_info + 2'd1;
		else
			counter_next = (in.pred_info == 2'b00) ? 2'b00 : in.pred_info - 2'd1;
	end

	assign in_ready = !out_valid || out_ready;
	assign accept = in_valid && in_ready;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			out_valid <= 1'b0;
			wb_needed <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
			wb_needed <= in_valid && is_jump;
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			wb.data <= link_pc;
			wb.PR <= in.dest_PR;
			wb.ROB_index <= in.ROB_index;
			notif.ROB_index <= in.ROB_index;
			notif.is_mispredict <= next_pc != in.pred_PC;
			notif.is_taken <= taken;
			notif.updated_pred_info <= counter_next;
			notif.start_PC <= in.PC;
			// restart PC, the target if taken and the fall-through otherwise
			notif.target_PC <= next_pc;
		end
	end

	assert property (@(posedge CLK) disable iff (!nRST)
		in_valid |-> in.op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR});

endmodule

// ==== verilog/bru_operand_stage.sv ====
`timescale 1ns/1ps

`include "bru_settings.svh"

module bru_operand_stage (
	input logic CLK,
	input logic nRST,

	input logic issue_valid,
	input bru_pkg::bru_issue_t issue,
	output logic issue_ready,

	input logic A_reg_read_resp_valid,
	input logic [31:0] A_reg_read_resp_data,
	input logic B_reg_read_resp_valid,
	input logic [31:0] B_reg_read_resp_data,

	input logic [`BRU_PRF_BANK_COUNT-1:0][31:0] forward_data_by_bank,

	output logic out_valid,
	output bru_pkg::bru_exec_in_t out,
	input logic out_ready
);
	import bru_pkg::*;

	bru_issue_t op_q;
	logic valid_q;
	// index 0 is A, index 1 is B
	logic [1:0] have_q;
	logic [1:0][31:0] data_q;
	logic [1:0] src_forward;
	logic [1:0][`BRU_LOG_PRF_BANK_COUNT-1:0] src_bank;
	logic [1:0] resp_valid;
	logic [1:0][31:0] resp_data;
	logic [1:0] present;
	logic [1:0][31:0] value;
	logic take;
	logic leave;

	assign src_forward = {op_q.B_forward, op_q.A_forward};
	assign src_bank = {op_q.B_bank, op_q.A_bank};
	assign resp_valid = {B_reg_read_resp_valid, A_reg_read_resp_valid};
	assign resp_data = {B_reg_read_resp_data, A_reg_read_resp_data};

	// captured value first, then forward bank, then read response
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			present[i] = have_q[i] | src_forward[i] | resp_valid[i];
			if (have_q[i])
				value[i] = data_q[i];
			else if (src_forward[i])
				value[i] = forward_data_by_bank[src_bank[i]];
			else
				value[i] = resp_data[i];
		end
	end

	assign out_valid = valid_q & (&present);
	assign leave = out_valid & out_ready;
	assign issue_ready = !valid_q | leave;
	assign take = issue_valid & issue_ready;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= 1'b0;
			have_q <= 2'b00;
		end else if (take) begin
			valid_q <= 1'b1;
			// zero operands are complete on arrival
			have_q <= {issue.B_unneeded_or_is_zero, issue.A_unneeded_or_is_zero};
		end else if (leave) begin
			valid_q <= 1'b0;
			have_q <= 2'b00;
		end else if (valid_q) begin
			have_q <= have_q | present;
		end
	end

	always_ff @(posedge CLK) begin
		if (take) begin
			op_q <= issue;
			data_q <= '0;
		end else begin
			data_q <= value;
		end
	end

	assign out.op = op_q.op;
	assign out.pred_info = op_q.pred_info;
	assign out.PC = op_q.PC;
	assign out.pred_PC = op_q.pred_PC;
	assign out.imm = op_q.imm;
	assign out.dest_PR = op_q.dest_PR;
	assign out.ROB_index = op_q.ROB_index;
	assign out.A = value[0];
	assign out.B = value[1];

	// responses only for a held op still waiting on that operand
	assert property (@(posedge CLK) disable iff (!nRST)
		(resp_valid & ~({2{valid_q}} & ~have_q & ~src_forward)) == 2'b00);

endmodule

// ==== verilog/bru_pkg.sv ====
`include "bru_settings.svh"

package bru_pkg;

	// jumps sit in the low codes, conditional branches above 8
	typedef enum logic [3:0] {
		JALR = 4'b0000,
		JAL  = 4'b0001,
		BEQ  = 4'b1000,
		BNE  = 4'b1001,
		BLT  = 4'b1100,
		BGE  = 4'b1101,
		BLTU = 4'b1110,
		BGEU = 4'b1111
	} bru_op_t;

	// ------------------------------------------------------------------------
	// immediate field
	// ------------------------------------------------------------------------

	// branch and jalr view, 12-bit offset in the low bits
	typedef struct packed {
		logic [7:0] pad;
		logic signed [11:0] offset;
	} bru_imm_br_t;

	// jal reads all 20 bits as a halfword offset
	typedef union packed {
		bru_imm_br_t br;
		logic signed [19:0] jal;
	} bru_imm_u;

	// ------------------------------------------------------------------------
	// pipeline payloads
	// ------------------------------------------------------------------------

	typedef struct packed {
		bru_op_t op;
		logic [1:0] pred_info;
		logic [31:0] PC;
		logic [31:0] pred_PC;
		bru_imm_u imm;
		logic A_unneeded_or_is_zero;
		logic A_forward;
		logic [`BRU_LOG_PRF_BANK_COUNT-1:0] A_bank;
		logic B_unneeded_or_is_zero;
		logic B_forward;
		logic [`BRU_LOG_PRF_BANK_COUNT-1:0] B_bank;
		logic [`BRU_LOG_PR_COUNT-1:0] dest_PR;
		logic [`BRU_LOG_ROB_ENTRIES-1:0] ROB_index;
	} bru_issue_t;

	// op with both operands resolved
	typedef struct packed {
		bru_op_t op;
		logic [1:0] pred_info;
		logic [31:0] PC;
		logic [31:0] pred_PC;
		bru_imm_u imm;
		logic [`BRU_LOG_PR_COUNT-1:0] dest_PR;
		logic [`BRU_LOG_ROB_ENTRIES-1:0] ROB_index;
		logic [31:0] A;
		logic [31:0] B;
	} bru_exec_in_t;

	typedef struct packed {
		logic [31:0] data;
		logic [`BRU_LOG_PR_COUNT-1:0] PR;
		logic [`BRU_LOG_ROB_ENTRIES-1:0] ROB_index;
	} bru_wb_t;

	typedef struct packed {
		logic [`BRU_LOG_ROB_ENTRIES-1:0] ROB_index;
		logic is_mispredict;
		logic is_taken;
		logic [1:0] updated_pred_info;
		logic [31:0] start_PC;
		logic [31:0] target_PC;
	} bru_notif_t;

endpackage

// ==== verilog/bru_settings.svh ====
`ifndef BRU_SETTINGS_SVH
`define BRU_SETTINGS_SVH

// ------------------------------------------------------------------------
// branch unit sizing
// ------------------------------------------------------------------------

// physical register tag width
`define BRU_LOG_PR_COUNT 7

// reorder buffer index width
`define BRU_LOG_ROB_ENTRIES 6

// register file forward banks
`define BRU_PRF_BANK_COUNT 4
`define BRU_LOG_PRF_BANK_COUNT 2

`endif
